// File: vga_cfg.svh
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// 640x480 at 60 Hz, horizontal timing in pixel clocks
`define VGA_H_DISPLAY 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_BACK 48
// 800 clocks per line
`define VGA_H_TOTAL (`VGA_H_DISPLAY + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)

// vertical timing in lines, the short front porch matches the reference
`define VGA_V_DISPLAY 480
`define VGA_V_FRONT 11
`define VGA_V_SYNC 2
`define VGA_V_BACK 31
// 524 lines per frame
`define VGA_V_TOTAL (`VGA_V_DISPLAY + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

// test pattern geometry
`define VGA_BAR_WIDTH 80
// checker squares of 2**5 = 32 pixels
`define VGA_CHECK_SHIFT 5

`endif

// File: vga_timing_pkg.sv
package vga_timing_pkg;

   // screen coordinate, wide enough for the 800 clock line
   typedef logic [9:0] coord_t;

   // both syncs are negative pulses at 640x480
   localparam logic SYNC_ACTIVE = 1'b0;
   localparam logic SYNC_IDLE   = ~SYNC_ACTIVE;

endpackage

// File: vga_pixel_pkg.sv
package vga_pixel_pkg;

   typedef struct packed {
      logic [3:0] r;                         // top nibble
      logic [3:0] g;
      logic [3:0] b;                         // bottom nibble
   } rgb444_fields_t;

   // one RGB444 word, seen either whole or per channel
   typedef union packed {
      logic [11:0]    raw;
      rgb444_fields_t fields;
   } rgb444_t;

   typedef enum logic [1:0] {
      PAT_SOLID    = 2'd0,
      PAT_BARS     = 2'd1,
      PAT_CHECKER  = 2'd2,
      PAT_GRADIENT = 2'd3
   } pattern_mode_t;

   // classic bar order: white yellow cyan green magenta red blue black
   function automatic rgb444_fields_t bar_color(input logic [2:0] idx);
      rgb444_fields_t c;
      c.r = {4{~idx[1]}};                    // on for bars 0,1,4,5
      c.g = {4{~idx[2]}};                    // on for the left half
      c.b = {4{~idx[0]}};                    // on for even bars
      return c;
   endfunction

endpackage

// File: vga_scan_if.sv
`timescale 1ns/1ps

// one scan position with its flags, passed stage to stage every clock
interface vga_scan_if;

   vga_timing_pkg::coord_t x;                // column, 0..799
   vga_timing_pkg::coord_t y;                // line, 0..523
   logic                   active;           // inside the 640x480 area
   logic                   hs;               // horizontal sync level
   logic                   vs;               // vertical sync level

   modport src (
      output x,
      output y,
      output active,
      output hs,
      output vs
   );

   modport dst (
      input  x,
      input  y,
      input  active,
      input  hs,
      input  vs
   );

endinterface

// File: vga_timing.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_timing (
   input  logic    i_clk,
   input  logic    i_rstn,
   vga_scan_if.src scan
);

   localparam int H_SYNC_START = `VGA_H_DISPLAY + `VGA_H_FRONT;    // 656
   localparam int H_SYNC_END   = H_SYNC_START + `VGA_H_SYNC;      // 752, exclusive
   localparam int V_SYNC_START = `VGA_V_DISPLAY + `VGA_V_FRONT;    // 491
   localparam int V_SYNC_END   = V_SYNC_START + `VGA_V_SYNC;      // 493, exclusive

   vga_timing_pkg::coord_t h_cnt;
   vga_timing_pkg::coord_t v_cnt;
   logic                   h_wrap;
   logic                   v_wrap;
   logic                   h_in_sync;
   logic                   v_in_sync;

   assign h_wrap = (h_cnt == `VGA_H_TOTAL - 1);
   assign v_wrap = (v_cnt == `VGA_V_TOTAL - 1);

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         h_cnt <= '0;
      end else if (h_wrap) begin
         h_cnt <= '0;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // line counter only moves at the end of a line
   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         v_cnt <= '0;
      end else if (h_wrap) begin
         if (v_wrap) begin
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + 1'b1;
         end
      end
   end

   assign h_in_sync = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
   assign v_in_sync = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

   // raw scan position, no register stage here
   assign scan.x      = h_cnt;
   assign scan.y      = v_cnt;
   assign scan.active = (h_cnt < `VGA_H_DISPLAY) && (v_cnt < `VGA_V_DISPLAY);
   assign scan.hs     = h_in_sync ? vga_timing_pkg::SYNC_ACTIVE : vga_timing_pkg::SYNC_IDLE;
   assign scan.vs     = v_in_sync ? vga_timing_pkg::SYNC_ACTIVE : vga_timing_pkg::SYNC_IDLE;

   a_h_range: assert property (
      @(posedge i_clk) disable iff (!i_rstn)
      h_cnt < `VGA_H_TOTAL
   );

   // a line step anywhere but the line end would shear the picture
   a_v_step: assert property (
      @(posedge i_clk) disable iff (!i_rstn)
      !h_wrap |=> $stable(v_cnt)
   );

endmodule

// File: vga_pattern_gen.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_pattern_gen (
   input  logic                         i_clk,
   input  logic                         i_rstn,
   input  vga_pixel_pkg::pattern_mode_t i_mode,
   input  vga_pixel_pkg::rgb444_t       i_color,
   vga_scan_if.dst                      scan_in,
   vga_scan_if.src                      scan_out,
   output vga_pixel_pkg::rgb444_t       o_pixel
);

   vga_pixel_pkg::pattern_mode_t mode_q;     // frame latch
   vga_pixel_pkg::rgb444_t       color_q;
   vga_pixel_pkg::pattern_mode_t mode_cur;   // what this position is drawn with
   vga_pixel_pkg::rgb444_t       color_cur;
   vga_pixel_pkg::rgb444_t       pix_d;
   logic                         frame_start;
   logic [2:0]                   bar_idx;
   logic                         check_on;

   assign frame_start = (scan_in.x == '0) && (scan_in.y == '0);

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         mode_q  <= vga_pixel_pkg::PAT_SOLID;
         color_q <= '0;
      end else if (frame_start) begin
         mode_q  <= i_mode;
         color_q <= i_color;
      end
   end

   // pixel (0,0) is registered on the latch edge, so bypass the latch there
   assign mode_cur  = frame_start ? i_mode : mode_q;
   assign color_cur = frame_start ? i_color : color_q;

   assign bar_idx  = 3'(scan_in.x / `VGA_BAR_WIDTH);   // wraps in blanking, masked later
   assign check_on = scan_in.x[`VGA_CHECK_SHIFT] ^ scan_in.y[`VGA_CHECK_SHIFT];

   always_comb begin
      pix_d = '0;
      case (mode_cur)
         vga_pixel_pkg::PAT_SOLID: begin
            pix_d.raw = color_cur.raw;
         end
         vga_pixel_pkg::PAT_BARS: begin
            pix_d.fields = vga_pixel_pkg::bar_color(bar_idx);
         end
         vga_pixel_pkg::PAT_CHECKER: begin
            pix_d.fields.r = {4{check_on}};
            pix_d.fields.g = {4{check_on}};
            pix_d.fields.b = {4{check_on}};
         end
         vga_pixel_pkg::PAT_GRADIENT: begin
            pix_d.raw = {scan_in.x[9:6], scan_in.y[8:5], scan_in.x[3:0]};
         end
         default: begin
            pix_d = '0;
         end
      endcase
   end

   // pixel and flags leave together
   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         o_pixel         <= '0;
         scan_out.active <= 1'b0;
         scan_out.hs     <= vga_timing_pkg::SYNC_IDLE;
         scan_out.vs     <= vga_timing_pkg::SYNC_IDLE;
      end else begin
         o_pixel         <= pix_d;
         scan_out.active <= scan_in.active;
         scan_out.hs     <= scan_in.hs;
         scan_out.vs     <= scan_in.vs;
      end
   end

   always_ff @(posedge i_clk) begin
      scan_out.x <= scan_in.x;
      scan_out.y <= scan_in.y;
   end

   // mode may only move on the edge that closes position (0,0)
   a_mode_frame: assert property (
      @(posedge i_clk) disable iff (!i_rstn)
      !$stable(mode_q) |-> $past(frame_start)
   );

endmodule

// File: vga_out_stage.sv
`timescale 1ns/1ps

module vga_out_stage (
   input  logic                   i_clk,
   input  logic                   i_rstn,
   vga_scan_if.dst                scan_in,
   input  vga_pixel_pkg::rgb444_t i_pixel,
   output logic [3:0]             o_vga_r,
   output logic [3:0]             o_vga_g,
   output logic [3:0]             o_vga_b,
   output logic                   o_vga_hs,
   output logic                   o_vga_vs,
   output logic                   o_display_active
);

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         o_vga_r          <= '0;
         o_vga_g          <= '0;
         o_vga_b          <= '0;
         o_vga_hs         <= vga_timing_pkg::SYNC_IDLE;
         o_vga_vs         <= vga_timing_pkg::SYNC_IDLE;
         o_display_active <= 1'b0;
      end else begin
         if (scan_in.active) begin
            o_vga_r <= i_pixel.fields.r;
            o_vga_g <= i_pixel.fields.g;
            o_vga_b <= i_pixel.fields.b;
         end else begin
            o_vga_r <= '0;                   // black in blanking
            o_vga_g <= '0;
            o_vga_b <= '0;
         end
         o_vga_hs         <= scan_in.hs;     // same edge as colour, no skew
         o_vga_vs         <= scan_in.vs;
         o_display_active <= scan_in.active;
      end
   end

   a_blank_black: assert property (
      @(posedge i_clk) disable iff (!i_rstn)
      !o_display_active |-> ({o_vga_r, o_vga_g, o_vga_b} == 12'h000)
   );

endmodule

// File: vga_top.sv
`timescale 1ns/1ps

module vga_top (
   input  logic        i_clk,
   input  logic        i_rstn,
   input  logic [1:0]  i_mode,
   input  logic [11:0] i_color,
   output logic [3:0]  o_vga_r,
   output logic [3:0]  o_vga_g,
   output logic [3:0]  o_vga_b,
   output logic        o_vga_hs,
   output logic        o_vga_vs,
   output logic        o_display_active
);

   vga_pixel_pkg::rgb444_t pixel;           // pattern stage to output stage

   vga_scan_if scan_raw ();                  // straight from the counters
   vga_scan_if scan_pix ();                  // one clock later

   vga_timing u_timing (
      .i_clk  (i_clk),
      .i_rstn (i_rstn),
      .scan   (scan_raw.src)
   );

   vga_pattern_gen u_pattern_gen (
      .i_clk    (i_clk),
      .i_rstn   (i_rstn),
      .i_mode   (vga_pixel_pkg::pattern_mode_t'(i_mode)),
      .i_color  (i_color),
      .scan_in  (scan_raw.dst),
      .scan_out (scan_pix.src),
      .o_pixel  (pixel)
   );

   vga_out_stage u_out_stage (
      .i_clk            (i_clk),
      .i_rstn           (i_rstn),
      .scan_in          (scan_pix.dst),
      .i_pixel          (pixel),
      .o_vga_r          (o_vga_r),
      .o_vga_g          (o_vga_g),
      .o_vga_b          (o_vga_b),
      .o_vga_hs         (o_vga_hs),
      .o_vga_vs         (o_vga_vs),
      .o_display_active (o_display_active)
   );

endmodule

// File: tb_vga_top.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module tb_vga_top;

   localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
   localparam int WAIT_LIMIT   = FRAME_CYCLES + 1000;         // a little over one frame
   localparam logic [14:0] RESET_OUT = {12'h000, 1'b1, 1'b1, 1'b0};

   logic        i_clk;
   logic        i_rstn;
   logic [1:0]  i_mode;
   logic [11:0] i_color;
   logic [3:0]  o_vga_r;
   logic [3:0]  o_vga_g;
   logic [3:0]  o_vga_b;
   logic        o_vga_hs;
   logic        o_vga_vs;
   logic        o_display_active;

   integer      seed;
   int          errors;
   int          timeouts;

   logic [9:0]  h_cnt;                                        // model scan position
   logic [9:0]  v_cnt;
   logic [1:0]  lat_mode;                                     // model frame latch
   logic [11:0] lat_color;
   logic [14:0] hist0;                                        // {r, g, b, hs, vs, active}
   logic [14:0] hist1;
   logic [14:0] exp_v;
   int          hist_fill;

   logic        prev_hs;
   logic        prev_vs;
   int          hs_low;
   int          hs_gap;
   int          hs_falls;
   int          vs_low;
   int          vs_gap;
   int          vs_falls;

   vga_top i_vga_top (
      .i_clk            (i_clk),
      .i_rstn           (i_rstn),
      .i_mode           (i_mode),
      .i_color          (i_color),
      .o_vga_r          (o_vga_r),
      .o_vga_g          (o_vga_g),
      .o_vga_b          (o_vga_b),
      .o_vga_hs         (o_vga_hs),
      .o_vga_vs         (o_vga_vs),
      .o_display_active (o_display_active)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   function automatic logic [14:0] expected_out(input logic [9:0] h, input logic [9:0] v,
                                                input logic [1:0] mode,
                                                input logic [11:0] color);
      vga_pixel_pkg::rgb444_fields_t bar;
      logic [11:0] rgb;
      logic        hs;
      logic        vs;
      logic        act;
      act = (h < `VGA_H_DISPLAY) && (v < `VGA_V_DISPLAY);
      hs  = vga_timing_pkg::SYNC_IDLE;
      vs  = vga_timing_pkg::SYNC_IDLE;
      if ((h >= 656) && (h <= 751)) begin
         hs = vga_timing_pkg::SYNC_ACTIVE;
      end
      if ((v >= 491) && (v <= 492)) begin
         vs = vga_timing_pkg::SYNC_ACTIVE;
      end
      case (mode)
         vga_pixel_pkg::PAT_SOLID: begin
            rgb = color;
         end
         vga_pixel_pkg::PAT_BARS: begin
            bar = vga_pixel_pkg::bar_color(3'(h / `VGA_BAR_WIDTH));
            rgb = {bar.r, bar.g, bar.b};
         end
         vga_pixel_pkg::PAT_CHECKER: begin
            rgb = {12{h[5] ^ v[5]}};                          // white where the bits differ
         end
         default: begin
            rgb = {h[9:6], v[8:5], h[3:0]};
         end
      endcase
      if (!act) begin
         rgb = 12'h000;
      end
      return {rgb, hs, vs, act};
   endfunction

   task automatic report_value(input string name, input int unsigned exp_val,
                               input int unsigned act_val);
      errors++;
      $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
   endtask

   task automatic drive_inputs(input logic [1:0] mode, input logic [11:0] color);
      @(posedge i_clk);
      i_mode  <= mode;
      i_color <= color;
   endtask

   // returns at the rising edge that starts the cycle holding position (x, y)
   task automatic wait_position(input logic [9:0] x, input logic [9:0] y);
      int cnt;
      cnt = 0;
      if (timeouts == 0) begin
         @(posedge i_clk);
         while (((h_cnt != x) || (v_cnt != y)) && (cnt < WAIT_LIMIT)) begin
            @(posedge i_clk);
            cnt++;
         end
         if (cnt >= WAIT_LIMIT) begin
            timeouts++;
            $display("timeout at %0t ns: scan position (%0d, %0d) was never reached",
                     $time, x, y);
         end
      end
   endtask

   // model and compare, mid-cycle where pins and inputs are settled
   always @(negedge i_clk) begin
      if (i_rstn) begin
         if ((h_cnt == '0) && (v_cnt == '0)) begin
            lat_mode  = i_mode;                               // new latch draws (0,0) too
            lat_color = i_color;
         end
         exp_v = (hist_fill < 2) ? RESET_OUT : hist1;
         if (o_vga_r !== exp_v[14:11]) begin
            report_value("o_vga_r", exp_v[14:11], o_vga_r);
         end
         if (o_vga_g !== exp_v[10:7]) begin
            report_value("o_vga_g", exp_v[10:7], o_vga_g);
         end
         if (o_vga_b !== exp_v[6:3]) begin
            report_value("o_vga_b", exp_v[6:3], o_vga_b);
         end
         if (o_vga_hs !== exp_v[2]) begin
            report_value("o_vga_hs", exp_v[2], o_vga_hs);
         end
         if (o_vga_vs !== exp_v[1]) begin
            report_value("o_vga_vs", exp_v[1], o_vga_vs);
         end
         if (o_display_active !== exp_v[0]) begin
            report_value("o_display_active", exp_v[0], o_display_active);
         end
         hist1 = hist0;                                       // two cycles to the pins
         hist0 = expected_out(h_cnt, v_cnt, lat_mode, lat_color);
         if (hist_fill < 2) begin
            hist_fill++;
         end
         if (h_cnt == `VGA_H_TOTAL - 1) begin
            h_cnt = '0;
            if (v_cnt == `VGA_V_TOTAL - 1) begin
               v_cnt = '0;
            end else begin
               v_cnt = v_cnt + 1'b1;
            end
         end else begin
            h_cnt = h_cnt + 1'b1;
         end
      end
   end

   // pulse width and repeat distance of both syncs
   always @(negedge i_clk) begin
      if (i_rstn) begin
         hs_gap++;
         if (prev_hs && !o_vga_hs) begin
            if ((hs_falls > 0) && (hs_gap != `VGA_H_TOTAL)) begin
               report_value("o_vga_hs period", `VGA_H_TOTAL, hs_gap);
            end
            hs_falls++;
            hs_gap = 0;
            hs_low = 0;
         end
         if (!o_vga_hs) begin
            hs_low++;
         end
         if (!prev_hs && o_vga_hs && (hs_falls > 0) && (hs_low != `VGA_H_SYNC)) begin
            report_value("o_vga_hs width", `VGA_H_SYNC, hs_low);
         end
         prev_hs = o_vga_hs;
         vs_gap++;
         if (prev_vs && !o_vga_vs) begin
            if ((vs_falls > 0) && (vs_gap != FRAME_CYCLES)) begin
               report_value("o_vga_vs period", FRAME_CYCLES, vs_gap);
            end
            vs_falls++;
            vs_gap = 0;
            vs_low = 0;
         end
         if (!o_vga_vs) begin
            vs_low++;
         end
         if (!prev_vs && o_vga_vs && (vs_falls > 0) && (vs_low != 2 * `VGA_H_TOTAL)) begin
            report_value("o_vga_vs width", 2 * `VGA_H_TOTAL, vs_low);
         end
         prev_vs = o_vga_vs;
      end
   end

   initial begin
      seed      = 32'hceda7c6b;
      errors    = 0;
      timeouts  = 0;
      h_cnt     = '0;
      v_cnt     = '0;
      lat_mode  = vga_pixel_pkg::PAT_SOLID;
      lat_color = 12'h000;
      hist0     = RESET_OUT;
      hist1     = RESET_OUT;
      hist_fill = 0;
      prev_hs   = 1'b1;
      prev_vs   = 1'b1;
      hs_low    = 0;
      hs_gap    = 0;
      hs_falls  = 0;
      vs_low    = 0;
      vs_gap    = 0;
      vs_falls  = 0;
      i_rstn    = 1'b0;
      i_mode    = vga_pixel_pkg::PAT_SOLID;
      i_color   = 12'h000;
      @(posedge i_clk);
      i_color <= 12'($random(seed));                          // frame 0 is solid
      repeat (7) @(posedge i_clk);
      i_rstn <= 1'b1;

      drive_inputs(vga_pixel_pkg::PAT_BARS, 12'h000);
      wait_position(10'd0, 10'd0);                            // frame 1 bars
      drive_inputs(vga_pixel_pkg::PAT_CHECKER, 12'h000);
      wait_position(10'd0, 10'd0);
      drive_inputs(vga_pixel_pkg::PAT_GRADIENT, 12'h000);
      wait_position(10'd0, 10'd0);
      drive_inputs(vga_pixel_pkg::PAT_SOLID, 12'($random(seed)));
      wait_position(10'd0, 10'd0);                            // frame 4 solid

      // change in mid frame, the picture must hold until frame 5
      wait_position(10'd0, 10'd240);
      drive_inputs(vga_pixel_pkg::PAT_BARS, 12'($random(seed)));
      wait_position(10'd0, 10'd0);
      wait_position(10'd0, 10'd8);

      if ((hs_falls < 2) || (vs_falls < 2)) begin
         errors++;
         $display("sync check incomplete: only %0d hsync and %0d vsync pulses were seen",
                  hs_falls, vs_falls);
      end
      $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if ((errors == 0) && (timeouts == 0)) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+.
vga_timing_pkg.sv
vga_pixel_pkg.sv
vga_scan_if.sv
vga_timing.sv
vga_pattern_gen.sv
vga_out_stage.sv
vga_top.sv
tb_vga_top.sv

// File: Makefile
SRCS = vga_cfg.svh vga_timing_pkg.sv vga_pixel_pkg.sv vga_scan_if.sv vga_timing.sv \
       vga_pattern_gen.sv vga_out_stage.sv vga_top.sv tb_vga_top.sv

.PHONY: run clean

run: obj_dir/Vtb_vga_top
	@out="$$(./obj_dir/Vtb_vga_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

obj_dir/Vtb_vga_top: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vga_top -f vlog.f

clean:
	rm -rf obj_dir
